// File: testbench/homeDisplayPatterns.txt
// columns: op_rooms_function_on_hold in hex, rooms bit 0 is room 0, function 1 is light
// op 1 load, 2 clear, 3 clear during draw, 4 random load with switches from xorshift
1_01_1_1_02 // room 0, light on
1_02_1_0_03 // room 1, light off
1_04_0_1_02 // room 2, door on
1_08_0_0_04 // room 3, door off
1_10_1_1_02 // room 4, right edge
1_16_0_1_03 // rooms 1, 2, 4 set, room 1 wins
1_1f_1_0_02
1_00_1_1_03 // no room set
2_00_0_0_01
4_00_0_0_02
4_00_0_0_03
4_00_0_0_02
3_04_1_1_02 // clear cuts the tile short
1_08_0_1_02 // draw again after the aborted one
4_00_0_0_05
2_00_0_0_03

// File: homeDisplay.f
source/homeDisplayPkg.sv
source/roomStatusIf.sv
source/drawCtrlIf.sv
source/displayControl.sv
source/roomStatusRegs.sv
source/pixelWriter.sv
source/homeDisplayTop.sv
testbench/homeDisplayMonitor.sv
testbench/homeDisplayTb.sv

// File: runSim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module homeDisplayTb -f homeDisplay.f \
	-o homeDisplaySim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/homeDisplaySim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Regression failed" sim.log; then
	exit 1
fi
exit 0

// File: testbench/homeDisplayTb.sv
`timescale 1ns/1ns
`default_nettype none

module homeDisplayTb;
	import homeDisplayPkg::*;

	localparam string patternFile = "testbench/homeDisplayPatterns.txt";
	localparam int clockPeriod = 100;
	localparam int resetCycles = 8;
	localparam logic [31:0] randomSeed = 32'he316;

	logic clock, reset, loadInputs, clearScreen, functionLight, statusOn;
	logic pixelPlot, cueValid, busy;
	logic [roomCount-1:0] roomSelect;
	coordX_t pixelX;
	coordY_t pixelY;
	colour_t pixelColour;
	cue_t cueCode;
	int testsRun, testsFailed, errorCount;
	logic [27:0] patterns [64]; // op, rooms, function, on/off, hold
	logic [31:0] randomState = randomSeed;
	int patternCount = 0;
	int cycleCount = 0;
	int cycleLimit = 0; // set once the pattern file is read

	homeDisplayTop i_homeDisplayTop (.*);
	homeDisplayMonitor monitor (.*);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	initial begin
		clock = 1'b0;
		forever #(clockPeriod / 2) clock = ~clock;
	end

	always @(posedge clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
			$display("timeout, the run was still going after %0d cycles", cycleLimit);
			$display("Regression failed");
			$finish;
		end
	end

	task automatic pulseClear(input int hold);
		clearScreen = 1'b1;
		repeat (hold) @(negedge clock);
		clearScreen = 1'b0;
		@(negedge clock); // clearing is entered by now
	endtask

	// load with an optional clear a few pixels into the tile
	task automatic runLoad(input string name, input logic [roomCount-1:0] rooms,
			input logic light, input logic on, input int hold, input bit clearMidway);
		int room = -1;
		cue_t code;
		for (int i = 0; i < roomCount; i++) begin
			if (rooms[i] && room < 0) begin
				room = i; // first set switch counting up from room 0
			end
		end
		case ({light, on})
			2'b11: code = cueLightOn;
			2'b10: code = cueLightOff;
			2'b01: code = cueDoorOn;
			default: code = cueDoorOff;
		endcase
		monitor.beginTest(name, room >= 0, clearMidway, room < 0 && !clearMidway,
			20 + 28 * room, light ? lightRowY : doorRowY, on ? colourOn : colourOff, code);
		roomSelect = rooms;
		functionLight = light;
		statusOn = on;
		loadInputs = 1'b1;
		repeat (hold) @(negedge clock);
		loadInputs = 1'b0;
		@(negedge clock); // release sampled here
		if (clearMidway) begin
			repeat (6) @(negedge clock);
			pulseClear(1);
		end
	endtask

	initial begin
		int sum;
		logic [27:0] line;
		reset = 1'b1;
		loadInputs = 1'b0;
		clearScreen = 1'b0;
		roomSelect = '0;
		functionLight = 1'b0;
		statusOn = 1'b0;
		foreach (patterns[i]) begin
			patterns[i] = '0; // op 0 marks the end of the list
		end
		$readmemh(patternFile, patterns);
		sum = 0;
		while (patternCount < 64 && patterns[patternCount][27:24] != 4'd0) begin
			line = patterns[patternCount];
			sum += line[7:0] + ((line[27:24] == 4'd2 || line[27:24] == 4'd3) ? 19300 : 40);
			patternCount++;
		end
		cycleLimit = 2 * sum + resetCycles + 10;
		repeat (resetCycles) @(negedge clock);
		reset = 1'b0;
		monitor.beginTest("idle after reset", 1'b0, 1'b0, 1'b1, 0, 0, 0, 0);
		repeat (4) @(negedge clock);
		monitor.endTest();
		for (int i = 0; i < patternCount; i++) begin
			line = patterns[i];
			case (line[27:24])
				4'd1: runLoad("load", line[20:16], line[12], line[8], line[7:0], 1'b0);
				4'd2: begin
					monitor.beginTest("clear", 1'b0, 1'b1, 1'b0, 0, 0, 0, 0);
					pulseClear(line[7:0]);
				end
				4'd3: runLoad("clear during draw", line[20:16], line[12], line[8], line[7:0], 1'b1);
				4'd4: begin
					randomState = xorshift(randomState);
					runLoad("random load", randomState[roomCount-1:0], randomState[5],
						randomState[6], line[7:0], 1'b0);
				end
				default: begin
					monitor.beginTest("unknown operation", 1'b0, 1'b0, 1'b1, 0, 0, 0, 0);
					monitor.noteFailure("the pattern line holds an unknown operation");
				end
			endcase
			while (busy) begin
				@(negedge clock);
			end
			monitor.endTest();
			repeat (2) @(negedge clock);
		end
		$display("tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed, errorCount);
		if (errorCount == 0 && patternCount > 0) begin
			$display("Regression passed");
		end else begin
			if (patternCount == 0) begin
				$display("no test patterns were read from %s", patternFile);
			end
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/homeDisplayMonitor.sv
`timescale 1ns/1ns
`default_nettype none

module homeDisplayMonitor (
	input logic clock,
	input logic reset,
	input homeDisplayPkg::coordX_t pixelX,
	input homeDisplayPkg::coordY_t pixelY,
	input homeDisplayPkg::colour_t pixelColour,
	input logic pixelPlot,
	input homeDisplayPkg::cue_t cueCode,
	input logic cueValid,
	input logic busy,
	output int testsRun,
	output int testsFailed,
	output int errorCount
);
	import homeDisplayPkg::*;

	localparam int sweepPixels = screenWidth * screenHeight;
	localparam int tilePixels = tileSize * tileSize;

	string testName;
	bit testOpen = 1'b0;
	bit expectTile, expectSweep, quietBusy; // what the running test should produce
	int expX, expY, expColour, expCue;
	int tileSeen, sweepSeen, cueSeen, testErrors;

	initial begin
		testsRun = 0;
		testsFailed = 0;
		errorCount = 0;
	end

	task automatic noteFailure(input string what);
		$display("ERROR at %0t ns in test %0d: %s", $time, testsRun + 1, what);
		testErrors++;
		errorCount++;
	endtask

	task automatic compareValue(input string signalName, input int expected, input int actual);
		if (expected != actual) begin
			$display("CHECK FAILED at %0t ns: %s expected %0d, got %0d", $time, signalName,
				expected, actual);
			testErrors++;
			errorCount++;
		end
	endtask

	task automatic beginTest(input string name, input bit tile, input bit sweep, input bit quiet,
			input int x, input int y, input int colour, input int code);
		testName = name;
		expectTile = tile;
		expectSweep = sweep;
		quietBusy = quiet;
		expX = x;
		expY = y;
		expColour = colour;
		expCue = code;
		tileSeen = 0;
		sweepSeen = 0;
		cueSeen = 0;
		testErrors = 0;
		testOpen = 1'b1;
	endtask

	task automatic checkPixel();
		// the sweep always opens with a black pixel at the origin
		if (expectSweep && (sweepSeen > 0 || !expectTile ||
				(pixelX == 0 && pixelY == 0 && pixelColour == colourClear))) begin
			compareValue("pixelX", sweepSeen % screenWidth, pixelX);
			compareValue("pixelY", sweepSeen / screenWidth, pixelY);
			compareValue("pixelColour", colourClear, pixelColour);
			sweepSeen++;
		end else if (expectTile && tileSeen < tilePixels) begin
			compareValue("pixelX", expX + tileSeen % tileSize, pixelX); // row-major in tile
			compareValue("pixelY", expY + tileSeen / tileSize, pixelY);
			compareValue("pixelColour", expColour, pixelColour);
			tileSeen++;
		end else begin
			noteFailure($sformatf("unexpected pixel at (%0d, %0d)", pixelX, pixelY));
		end
	endtask

	task automatic endTest();
		if (expectTile && !expectSweep && (tileSeen != tilePixels || cueSeen != 1)) begin
			noteFailure($sformatf("tile gave %0d pixels and %0d cues instead of %0d and 1",
				tileSeen, cueSeen, tilePixels));
		end
		if (expectSweep && sweepSeen != sweepPixels) begin
			noteFailure($sformatf("clear gave %0d black pixels instead of %0d", sweepSeen,
				sweepPixels));
		end
		if (expectSweep && expectTile && tileSeen >= tilePixels) begin
			noteFailure("the tile was not cut short by the clear");
		end
		testsRun++;
		if (testErrors > 0) begin
			testsFailed++;
		end
		$display("test %0d %s: %0d errors", testsRun, testName, testErrors);
		testOpen = 1'b0;
	endtask

	always @(negedge clock) begin
		if (!reset) begin
			if (testOpen) begin
				if (pixelPlot) begin
					checkPixel();
				end
				if (cueValid) begin
					cueSeen++;
					if (expectTile && !expectSweep && tileSeen == tilePixels) begin
						compareValue("cueCode", expCue, cueCode);
					end else begin
						noteFailure("cue issued without a completed tile");
					end
				end
				if (quietBusy && busy) begin
					noteFailure("busy went high with nothing to draw");
				end
			end else if (pixelPlot || cueValid || busy) begin
				noteFailure("the DUT was active between tests");
			end
		end
	end

endmodule

`default_nettype wire

// File: source/homeDisplayTop.sv
`timescale 1ns/1ns
`default_nettype none

module homeDisplayTop (
	input logic clock,
	input logic reset,
	input logic loadInputs,
	input logic clearScreen,
	input logic [homeDisplayPkg::roomCount-1:0] roomSelect,
	input logic functionLight,
	input logic statusOn,
	output homeDisplayPkg::coordX_t pixelX,
	output homeDisplayPkg::coordY_t pixelY,
	output homeDisplayPkg::colour_t pixelColour,
	output logic pixelPlot,
	output homeDisplayPkg::cue_t cueCode,
	output logic cueValid,
	output logic busy
);

	logic captureEnable;

	roomStatusIf roomStatus ();
	drawCtrlIf drawCtrl ();

	displayControl i_displayControl (
		.clock(clock),
		.reset(reset),
		.loadInputs(loadInputs),
		.clearScreen(clearScreen),
		.roomValid(roomStatus.roomValid),
		.ctrl(drawCtrl.control),
		.captureEnable(captureEnable),
		.cueValid(cueValid),
		.busy(busy)
	);

	roomStatusRegs i_roomStatusRegs (
		.clock(clock),
		.reset(reset),
		.captureEnable(captureEnable),
		.roomSelect(roomSelect),
		.functionLight(functionLight),
		.statusOn(statusOn),
		.status(roomStatus.owner),
		.cueCode(cueCode)
	);

	pixelWriter i_pixelWriter (
		.clock(clock),
		.reset(reset),
		.status(roomStatus.reader),
		.ctrl(drawCtrl.writer),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.pixelColour(pixelColour),
		.pixelPlot(pixelPlot)
	);

endmodule

`default_nettype wire

// File: source/pixelWriter.sv
`timescale 1ns/1ns
`default_nettype none

module pixelWriter (
	input logic clock,
	input logic reset,
	roomStatusIf.reader status,
	drawCtrlIf.writer ctrl,
	output homeDisplayPkg::coordX_t pixelX,
	output homeDisplayPkg::coordY_t pixelY,
	output homeDisplayPkg::colour_t pixelColour,
	output logic pixelPlot
);
	import homeDisplayPkg::*;

	logic [3:0] tileCount; // row in [3:2], column in [1:0]
	coordX_t sweepX;
	coordY_t sweepY;
	logic tilePlot;
	logic sweepPlot;
	logic tileLast;
	logic sweepLast;

	// hold off for the cycle in which the done pulse is out
	assign tilePlot = ctrl.drawActive && !ctrl.tileDone;
	assign sweepPlot = ctrl.clearActive && !ctrl.clearDone;
	assign tileLast = tileCount == 4'(tileSize * tileSize - 1);
	assign sweepLast = (sweepX == coordX_t'(screenWidth - 1)) &&
		(sweepY == coordY_t'(screenHeight - 1));

	always_ff @(posedge clock) begin
		if (reset || !ctrl.drawActive) begin
			tileCount <= '0;
		end else if (tilePlot) begin
			tileCount <= tileCount + 1'b1; // wraps to 0 after the last pixel
		end
	end

	always_ff @(posedge clock) begin
		if (reset || !ctrl.clearActive) begin
			sweepX <= '0;
			sweepY <= '0;
		end else if (sweepPlot) begin
			if (sweepX == coordX_t'(screenWidth - 1)) begin
				sweepX <= '0;
				sweepY <= sweepLast ? '0 : sweepY + 1'b1; // next row, or back to top
			end else begin
				sweepX <= sweepX + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			pixelPlot <= 1'b0;
			ctrl.tileDone <= 1'b0;
			ctrl.clearDone <= 1'b0;
		end else begin
			pixelPlot <= tilePlot || sweepPlot;
			ctrl.tileDone <= tilePlot && tileLast;
			ctrl.clearDone <= sweepPlot && sweepLast;
		end
	end

	always_ff @(posedge clock) begin
		if (sweepPlot) begin
			pixelX <= sweepX;
			pixelY <= sweepY;
			pixelColour <= colourClear;
		end else begin
			pixelX <= status.tileX + coordX_t'(tileCount[1:0]);
			pixelY <= status.tileY + coordY_t'(tileCount[3:2]);
			pixelColour <= status.tileColour;
		end
	end

	pixelOnScreen: assert property (@(posedge clock) disable iff (reset)
		pixelPlot |-> (pixelX < screenWidth) && (pixelY < screenHeight));

endmodule

`default_nettype wire

// File: source/roomStatusRegs.sv
`timescale 1ns/1ns
`default_nettype none

module roomStatusRegs (
	input logic clock,
	input logic reset,
	input logic captureEnable,
	input logic [homeDisplayPkg::roomCount-1:0] roomSelect,
	input logic functionLight,
	input logic statusOn,
	roomStatusIf.owner status,
	output homeDisplayPkg::cue_t cueCode
);
	import homeDisplayPkg::*;

	roomIndex_t lowestRoom;
	roomIndex_t roomReg;
	logic validReg;
	logic functionReg; // 1 = light, 0 = door
	logic onReg;

	// priority encode, lowest set switch wins
	always_comb begin
		lowestRoom = '0;
		for (int i = roomCount - 1; i >= 0; i--) begin
			if (roomSelect[i]) begin
				lowestRoom = roomIndex_t'(i);
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			validReg <= 1'b0;
		end else if (captureEnable) begin
			validReg <= |roomSelect;
		end
	end

	always_ff @(posedge clock) begin
		if (captureEnable) begin
			roomReg <= lowestRoom;
			functionReg <= functionLight;
			onReg <= statusOn;
		end
	end

	assign status.roomValid = validReg;
	assign status.tileX = roomBaseX[roomReg];
	assign status.tileY = functionReg ? lightRowY : doorRowY; // light row above door row
	assign status.tileColour = onReg ? colourOn : colourOff;

	always_comb begin
		if (functionReg) begin
			cueCode = onReg ? cueLightOn : cueLightOff;
		end else begin
			cueCode = onReg ? cueDoorOn : cueDoorOff;
		end
	end

	tileInsideScreen: assert property (@(posedge clock) disable iff (reset)
		status.roomValid |-> (int'(status.tileX) + tileSize <= screenWidth));

endmodule

`default_nettype wire

// File: source/displayControl.sv
`timescale 1ns/1ns
`default_nettype none

module displayControl (
	input logic clock,
	input logic reset,
	input logic loadInputs,
	input logic clearScreen,
	input logic roomValid,
	drawCtrlIf.control ctrl,
	output logic captureEnable,
	output logic cueValid,
	output logic busy
);
	import homeDisplayPkg::*;

	controlState_t state;
	controlState_t nextState;

	always_comb begin
		nextState = state;
		case (state)
			idle: begin
				if (loadInputs) begin
					nextState = loading;
				end
			end
			loading: begin
				if (!loadInputs) begin
					nextState = roomValid ? drawing : idle; // nothing to draw without a room
				end
			end
			drawing: begin
				if (ctrl.tileDone) begin
					nextState = cue;
				end
			end
			cue: nextState = idle;
			clearing: begin
				if (ctrl.clearDone) begin
					nextState = idle;
				end
			end
			default: nextState = idle;
		endcase
		// clear wins over everything, including a draw in progress
		if (clearScreen) begin
			nextState = clearing;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= idle;
		end else begin
			state <= nextState;
		end
	end

	assign captureEnable = state == loading; // latch switches while button held
	assign ctrl.drawActive = state == drawing;
	assign ctrl.clearActive = state == clearing;
	assign cueValid = state == cue;
	assign busy = (state == drawing) || (state == cue) || (state == clearing);

	// the writer must never be asked to draw and sweep at once
	activeExclusive: assert property (@(posedge clock) disable iff (reset)
		!(ctrl.drawActive && ctrl.clearActive));

	cueSingleCycle: assert property (@(posedge clock) disable iff (reset)
		cueValid |=> !cueValid);

endmodule

`default_nettype wire

// File: source/drawCtrlIf.sv
`timescale 1ns/1ns
`default_nettype none

interface drawCtrlIf;

	logic drawActive; // level, tile plot in progress
	logic clearActive; // level, screen sweep in progress
	logic tileDone; // pulse with last tile pixel
	logic clearDone; // pulse with last sweep pixel

	modport control(output drawActive, clearActive, input tileDone, clearDone);
	modport writer(input drawActive, clearActive, output tileDone, clearDone);

endinterface

`default_nettype wire

// File: source/roomStatusIf.sv
`timescale 1ns/1ns
`default_nettype none

interface roomStatusIf;
	import homeDisplayPkg::*;

	logic roomValid; // a room switch was set at the last load
	coordX_t tileX;
	coordY_t tileY;
	colour_t tileColour;

	modport owner(output roomValid, tileX, tileY, tileColour);
	modport reader(input tileX, tileY, tileColour);

endinterface

`default_nettype wire

// File: source/homeDisplayPkg.sv
`default_nettype none

package homeDisplayPkg;

	localparam int screenWidth = 160;
	localparam int screenHeight = 120;
	localparam int coordXWidth = 8;
	localparam int coordYWidth = 7;
	localparam int tileSize = 4; // tile edge, 16 pixels per tile
	localparam int roomCount = 5;
	localparam int colourWidth = 3;
	localparam int cueWidth = 2;

	typedef logic [2:0] roomIndex_t;
	typedef logic [coordXWidth-1:0] coordX_t;
	typedef logic [coordYWidth-1:0] coordY_t;
	typedef logic [colourWidth-1:0] colour_t;
	typedef logic [cueWidth-1:0] cue_t;

	localparam colour_t colourOn = 3'd6; // yellow
	localparam colour_t colourOff = 3'd7; // white
	localparam colour_t colourClear = 3'd0; // black

	localparam cue_t cueLightOn = 2'd0;
	localparam cue_t cueLightOff = 2'd1;
	localparam cue_t cueDoorOn = 2'd2;
	localparam cue_t cueDoorOff = 2'd3;

	typedef enum logic [2:0] {idle, loading, drawing, cue, clearing} controlState_t;

	// start column per room, 20 + 28 * room
	localparam coordX_t roomBaseX [roomCount] = '{8'd20, 8'd48, 8'd76, 8'd104, 8'd132};
	localparam coordY_t lightRowY = 7'd40;
	localparam coordY_t doorRowY = 7'd70;

endpackage

`default_nettype wire
